/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing -j 0
TOP      := receiver_tb
FILELIST := receiver.f
OBJ_DIR  := obj_dir

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) dv/receiver_tb_tasks.svh

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)

/* dv/receiver_tb_tasks.svh */
`ifndef RECEIVER_TB_TASKS_SVH
`define RECEIVER_TB_TASKS_SVH

// ----------------------------------------------------------------------
// input drivers that change on the falling edge
// ----------------------------------------------------------------------
task automatic init_inputs();
    clk          = 1'b0;
    reset_n      = 1'b0;
    sample       = '0;
    sample_valid = 1'b0;
    cfo_inc      = '0;
    cfo_valid    = 1'b0;
    cell_id      = '0;
    n_id_2_valid = 1'b0;
    n_id_valid   = 1'b0;
    ibar_valid   = 1'b0;
    llr          = '0;
    llr_valid    = 1'b0;
    req          = 1'b0;
    bus_req      = '0;
endtask

task automatic drive_sample(input iq_sample_t s, input logic valid);
    @(negedge clk);
    sample       = s;
    sample_valid = valid;
    @(negedge clk);
    sample_valid = 1'b0;
endtask

task automatic drive_cfo(input cfo_inc_t inc, input logic inc_valid, input logic samp_valid);
    @(negedge clk);
    cfo_inc      = inc;
    cfo_valid    = inc_valid;
    sample_valid = samp_valid;
    @(negedge clk);
    cfo_valid    = 1'b0;
    sample_valid = 1'b0;
endtask

task automatic drive_cell_id(input cell_id_t id, input logic v_n_id_2, input logic v_n_id,
                             input logic v_ibar);
    @(negedge clk);
    cell_id      = id;
    n_id_2_valid = v_n_id_2;
    n_id_valid   = v_n_id;
    ibar_valid   = v_ibar;
    @(negedge clk);
    n_id_2_valid = 1'b0;
    n_id_valid   = 1'b0;
    ibar_valid   = 1'b0;
endtask

task automatic drive_llr(input llr_beat_t beat, input logic valid);
    @(negedge clk);
    llr       = beat;
    llr_valid = valid;
    @(negedge clk);
    llr_valid = 1'b0;
endtask

// ----------------------------------------------------------------------
// four-phase register bus
// ----------------------------------------------------------------------
task automatic bus_access(input logic is_write, input reg_addr_e addr,
                          input logic [REG_DW-1:0] wdata, output logic [REG_DW-1:0] data);
    int cycles;
    @(negedge clk);
    bus_req = '{write: is_write, addr: addr, wdata: wdata};
    req     = 1'b1;
    cycles  = 0;
    do begin
        @(negedge clk);
        cycles++;
    end while (!ack && cycles < BUS_TIMEOUT);
    if (!ack) begin
        $display("bus access to %s was never acknowledged", addr.name());
        error_count++;
    end
    data   = rdata;
    req    = 1'b0;
    cycles = 0;
    while (ack && cycles < BUS_TIMEOUT) begin
        @(negedge clk);
        cycles++;
    end
    if (ack) begin
        $display("ack stayed high after the request to %s was dropped", addr.name());
        error_count++;
    end
endtask

task automatic bus_read(input reg_addr_e addr, output logic [REG_DW-1:0] data);
    bus_access(1'b0, addr, '0, data);
endtask

task automatic bus_write(input reg_addr_e addr, input logic [REG_DW-1:0] wdata);
    logic [REG_DW-1:0] unused_data;
    bus_access(1'b1, addr, wdata, unused_data);
endtask

// ----------------------------------------------------------------------
// typed compares and reporting
// ----------------------------------------------------------------------
task automatic compare_reg(input string name, input logic [REG_DW-1:0] expected,
                           input logic [REG_DW-1:0] actual);
    if (actual !== expected) begin
        $display("mismatch %s: expected 0x%h, got 0x%h", name, expected, actual);
        error_count++;
    end
endtask

task automatic compare_phase(input string name, input phase_t expected, input phase_t actual);
    if (actual !== expected) begin
        $display("mismatch %s: expected 0x%h, got 0x%h", name, expected, actual);
        error_count++;
    end
endtask

task automatic compare_llr(input string name, input llr_beat_t expected,
                           input llr_beat_t actual);
    if (actual !== expected) begin
        $display("mismatch %s: expected 0x%h, got 0x%h", name, expected, actual);
        error_count++;
    end
endtask

task automatic report_test(input string name, input int errors_before);
    tests_run++;
    $display("%s: %0d errors", name, error_count - errors_before);
endtask

`endif

/* dv/receiver_tb.sv */
module receiver_tb;
    import rx_pkg::*;
    import reg_pkg::*;

    localparam int NUM_TESTS   = 6;
    localparam int BUS_TIMEOUT = 16;

    logic              clk;
    logic              reset_n;
    iq_sample_t        sample;
    logic              sample_valid;
    cfo_inc_t          cfo_inc;
    logic              cfo_valid;
    cell_id_t          cell_id;
    logic              n_id_2_valid;
    logic              n_id_valid;
    logic              ibar_valid;
    llr_beat_t         llr;
    logic              llr_valid;
    logic              req;
    bus_req_t          bus_req;
    logic              ack;
    logic [REG_DW-1:0] rdata;
    phase_t            phase;

    int       error_count;
    int       tests_run;
    // reference model of the cfo accumulator
    logic     cfo_manual;
    cfo_inc_t model_acc;
    phase_t   model_phase;

    `include "receiver_tb_tasks.svh"

    receiver_top UUT (
        .clk_i          (clk),
        .reset_ni       (reset_n),
        .sample_i       (sample),
        .sample_valid_i (sample_valid),
        .cfo_inc_i      (cfo_inc),
        .cfo_valid_i    (cfo_valid),
        .cell_id_i      (cell_id),
        .n_id_2_valid_i (n_id_2_valid),
        .n_id_valid_i   (n_id_valid),
        .ibar_valid_i   (ibar_valid),
        .llr_i          (llr),
        .llr_valid_i    (llr_valid),
        .req_i          (req),
        .bus_req_i      (bus_req),
        .ack_o          (ack),
        .rdata_o        (rdata),
        .phase_o        (phase)
    );

    always #5 clk = ~clk;

    // ----------------------------------------------------------------------
    // cfo model steps
    // ----------------------------------------------------------------------
    task automatic cfo_step(input cfo_inc_t inc, input logic inc_valid, input logic samp_valid);
        if (cfo_manual) begin
            model_acc   = '0;
            model_phase = '0;
        end else begin
            // phase uses the increment held before this step
            if (samp_valid) model_phase = model_phase + phase_t'(model_acc);
            if (inc_valid) model_acc = model_acc - inc;
        end
        drive_cfo(inc, inc_valid, samp_valid);
        compare_phase("phase_o", model_phase, phase);
    endtask

    task automatic random_cfo_steps(input int steps);
        logic [31:0] rnd;
        for (int i = 0; i < steps; i++) begin
            rnd = $urandom();
            cfo_step(cfo_inc_t'(rnd[19:0]), rnd[21:20] != 2'b00, rnd[23:22] != 2'b00);
        end
    endtask

    task automatic check_cfo_inc_reg();
        logic [REG_DW-1:0] data;
        bus_read(REG_CFO_INC, data);
        compare_reg("REG_CFO_INC",
                    {{(REG_DW - DDS_PHASE_DW){model_acc[DDS_PHASE_DW-1]}}, model_acc}, data);
    endtask

    task automatic read_pbch_beat(input llr_beat_t expected);
        logic [REG_DW-1:0] data;
        llr_beat_t         actual;
        bus_read(REG_PBCH_DATA, data);
        actual.data = data[LLR_DW-1:0];
        actual.kind = LLR_PBCH;
        actual.last = data[PBCH_LAST_BIT];
        compare_llr("REG_PBCH_DATA", expected, actual);
        compare_reg("REG_PBCH_DATA upper bits", '0, data >> (PBCH_LAST_BIT + 1));
    endtask

    // ----------------------------------------------------------------------
    // directed tests
    // ----------------------------------------------------------------------
    task automatic test_cell_id_latch();
        int          errors_before;
        logic [31:0] rnd;
        logic [31:0] rnd_fields;
        logic [31:0] data;
        logic [9:0]  exp_n_id;
        logic [1:0]  exp_n_id_2;
        logic [2:0]  exp_ibar;
        cell_id_t    id;
        errors_before = error_count;
        exp_n_id      = '0;
        exp_n_id_2    = '0;
        exp_ibar      = '0;
        bus_read(REG_CELL_ID, data);
        compare_reg("REG_CELL_ID", '0, data);
        for (int i = 0; i < 10; i++) begin
            rnd         = $urandom_range(N_ID_MAX, 0);
            rnd_fields  = $urandom();
            id.n_id     = rnd[9:0];
            id.n_id_2   = rnd_fields[1:0];
            id.ibar_ssb = rnd_fields[4:2];
            drive_cell_id(id, rnd_fields[5], rnd_fields[6], rnd_fields[7]);
            if (rnd_fields[5]) exp_n_id_2 = id.n_id_2;
            if (rnd_fields[6]) exp_n_id = id.n_id;
            if (rnd_fields[7]) exp_ibar = id.ibar_ssb;
            bus_read(REG_CELL_ID, data);
            compare_reg("REG_CELL_ID", {17'd0, exp_n_id, exp_n_id_2, exp_ibar}, data);
        end
        report_test("cell identity latch", errors_before);
    endtask

    task automatic test_sample_capture();
        int          errors_before;
        logic [31:0] rnd;
        logic [31:0] expected;
        logic [31:0] data;
        iq_sample_t  s;
        errors_before = error_count;
        expected      = '0;
        for (int i = 0; i < 8; i++) begin
            rnd  = $urandom();
            s.im = rnd[31:16];
            s.re = rnd[15:0];
            // every third sample arrives without valid
            drive_sample(s, (i % 3) != 2);
            if ((i % 3) != 2) expected = {s.im, s.re};
            bus_read(REG_RX_SAMPLE, data);
            compare_reg("REG_RX_SAMPLE", expected, data);
        end
        report_test("sample capture", errors_before);
    endtask

    task automatic test_cfo_tracking();
        int errors_before;
        errors_before = error_count;
        cfo_manual    = 1'b0;
        model_acc     = '0;
        model_phase   = '0;
        random_cfo_steps(16);
        check_cfo_inc_reg();
        report_test("cfo tracking", errors_before);
    endtask

    task automatic test_cfo_manual();
        int                errors_before;
        logic [REG_DW-1:0] data;
        errors_before = error_count;
        bus_write(REG_CFO_MODE, 32'd1);
        cfo_manual  = 1'b1;
        model_acc   = '0;
        model_phase = '0;
        compare_phase("phase_o", '0, phase);
        random_cfo_steps(8);
        bus_read(REG_CFO_MODE, data);
        compare_reg("REG_CFO_MODE", 32'd1, data);
        check_cfo_inc_reg();
        // tracking again restarts accumulation from zero
        bus_write(REG_CFO_MODE, 32'd0);
        cfo_manual = 1'b0;
        compare_phase("phase_o", '0, phase);
        random_cfo_steps(8);
        check_cfo_inc_reg();
        report_test("cfo manual mode", errors_before);
    endtask

    task automatic test_pbch_filtering();
        int                errors_before;
        logic [31:0]       rnd;
        logic [REG_DW-1:0] data;
        logic              valid;
        llr_beat_t         beat;
        llr_beat_t         expected_q[$];
        errors_before = error_count;
        for (int i = 0; i < 14; i++) begin
            rnd       = $urandom();
            beat.data = rnd[7:0];
            beat.kind = rnd[13] ? LLR_PBCH : llr_kind_e'(rnd[9:8]);
            beat.last = rnd[10];
            valid     = (rnd[12:11] != 2'b00);
            drive_llr(beat, valid);
            if (valid && beat.kind == LLR_PBCH) expected_q.push_back(beat);
        end
        bus_read(REG_PBCH_LEVEL, data);
        compare_reg("REG_PBCH_LEVEL", REG_DW'(expected_q.size()), data);
        foreach (expected_q[i]) read_pbch_beat(expected_q[i]);
        // empty fifo reads as zero
        bus_read(REG_PBCH_DATA, data);
        compare_reg("REG_PBCH_DATA", '0, data);
        bus_read(REG_PBCH_LEVEL, data);
        compare_reg("REG_PBCH_LEVEL", '0, data);
        report_test("pbch filtering", errors_before);
    endtask

    task automatic test_pbch_overflow();
        int                errors_before;
        logic [31:0]       rnd;
        logic [REG_DW-1:0] data;
        llr_beat_t         beat;
        llr_beat_t         expected_q[$];
        errors_before = error_count;
        bus_write(REG_PBCH_LEVEL, '0);
        for (int i = 0; i < PBCH_FIFO_DEPTH + 2; i++) begin
            rnd       = $urandom();
            beat.data = rnd[7:0];
            beat.kind = LLR_PBCH;
            beat.last = rnd[8];
            drive_llr(beat, 1'b1);
            if (i < PBCH_FIFO_DEPTH) expected_q.push_back(beat);
        end
        // level 16 with overflow in bit 31
        bus_read(REG_PBCH_LEVEL, data);
        compare_reg("REG_PBCH_LEVEL", 32'h8000_0010, data);
        foreach (expected_q[i]) read_pbch_beat(expected_q[i]);
        bus_read(REG_PBCH_LEVEL, data);
        compare_reg("REG_PBCH_LEVEL", 32'h8000_0000, data);
        bus_write(REG_PBCH_LEVEL, '0);
        bus_read(REG_PBCH_LEVEL, data);
        compare_reg("REG_PBCH_LEVEL", '0, data);
        report_test("pbch overflow and clear", errors_before);
    endtask

    // ----------------------------------------------------------------------
    // sequence and watchdog
    // ----------------------------------------------------------------------
    initial begin
        error_count = 0;
        tests_run   = 0;
        cfo_manual  = 1'b0;
        model_acc   = '0;
        model_phase = '0;
        void'($urandom(9));
        init_inputs();
        repeat (2) @(negedge clk);
        reset_n = 1'b1;
        test_cell_id_latch();
        test_sample_capture();
        test_cfo_tracking();
        test_cfo_manual();
        test_pbch_filtering();
        test_pbch_overflow();
        $display("tests run: %0d, errors: %0d", tests_run, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(NUM_TESTS * 2000);
        $display("watchdog expired before the test sequence completed");
        $display("Test failed");
        $finish;
    end

endmodule

/* receiver.f */
+incdir+dv
source/rx_pkg.sv
source/reg_pkg.sv
source/cfo_phase_acc.sv
source/cell_status.sv
source/pbch_llr_fifo.sv
source/reg_bus_slave.sv
source/receiver_top.sv
dv/receiver_tb.sv

/* source/cell_status.sv */
module cell_status (
    input  logic               clk_i,
    input  logic               reset_ni,
    input  rx_pkg::iq_sample_t sample_i,
    input  logic               sample_valid_i,
    input  rx_pkg::cell_id_t   cell_id_i,
    input  logic               n_id_2_valid_i,
    input  logic               n_id_valid_i,
    input  logic               ibar_valid_i,
    output rx_pkg::iq_sample_t last_sample_o,
    output rx_pkg::cell_id_t   cell_id_o
);
    import rx_pkg::*;

    iq_sample_t sample_q;
    cell_id_t   cell_id_q;

    // last valid baseband sample
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            sample_q <= '0;
        end else if (sample_valid_i) begin
            sample_q <= sample_i;
        end
    end

    // each field latched on its own valid
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            cell_id_q <= '0;
        end else begin
            if (n_id_2_valid_i) begin
                cell_id_q.n_id_2 <= cell_id_i.n_id_2;
            end
            if (n_id_valid_i) begin
                cell_id_q.n_id <= cell_id_i.n_id;
            end
            if (ibar_valid_i) begin
                cell_id_q.ibar_ssb <= cell_id_i.ibar_ssb;
            end
        end
    end

    assign last_sample_o = sample_q;
    assign cell_id_o     = cell_id_q;

endmodule

/* source/cfo_phase_acc.sv */
module cfo_phase_acc (
    input  logic              clk_i,
    input  logic              reset_ni,
    input  logic              sample_valid_i,
    input  rx_pkg::cfo_inc_t  cfo_inc_i,
    input  logic              cfo_valid_i,
    input  rx_pkg::cfo_mode_e cfo_mode_i,
    output rx_pkg::cfo_inc_t  cfo_acc_o,
    output rx_pkg::phase_t    phase_o
);
    import rx_pkg::*;

    cfo_inc_t cfo_acc_q;
    phase_t   phase_q;

    // ----------------------------------------------------------------------
    // increment tracking and phase accumulation
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            cfo_acc_q <= '0;
            phase_q   <= '0;
        end else if (cfo_mode_i == CFO_MANUAL) begin
            cfo_acc_q <= '0;
            phase_q   <= '0;
        end else begin
            // detector reports relative to the previous estimate
            if (cfo_valid_i) begin
                cfo_acc_q <= cfo_acc_q - cfo_inc_i;
            end
            // phase wraps mod 2^20 using the increment held before this edge
            if (sample_valid_i) begin
                phase_q <= phase_q + phase_t'(cfo_acc_q);
            end
        end
    end

    assign cfo_acc_o = cfo_acc_q;
    assign phase_o   = phase_q;

endmodule

/* source/pbch_llr_fifo.sv */
module pbch_llr_fifo (
    input  logic                  clk_i,
    input  logic                  reset_ni,
    input  rx_pkg::llr_beat_t     llr_i,
    input  logic                  llr_valid_i,
    input  logic                  pop_i,
    input  logic                  clear_i,
    output rx_pkg::llr_beat_t     head_o,
    output reg_pkg::pbch_status_t status_o
);
    import rx_pkg::*;

    typedef struct packed {
        logic [LLR_DW-1:0] data;
        logic              last;
    } fifo_word_t;

    fifo_word_t            mem_q [PBCH_FIFO_DEPTH];
    logic [PBCH_PTR_W-1:0] wr_ptr_q;
    logic [PBCH_PTR_W-1:0] rd_ptr_q;
    logic [PBCH_PTR_W:0]   count_q;
    logic                  overflow_q;
    logic                  is_pbch;
    logic                  empty;
    logic                  full;
    logic                  do_push;
    logic                  do_pop;

    assign is_pbch = llr_valid_i && (llr_i.kind == LLR_PBCH);
    assign empty   = (count_q == '0);
    assign full    = (count_q == (PBCH_PTR_W + 1)'(PBCH_FIFO_DEPTH));
    // clear wins over everything else in the same cycle
    assign do_pop  = pop_i && !empty && !clear_i;
    assign do_push = is_pbch && (!full || do_pop) && !clear_i;

    // ----------------------------------------------------------------------
    // pointers, level and sticky overflow
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni || clear_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            overflow_q <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10: count_q <= count_q + 1'b1;
                2'b01: count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            // beat lost for lack of space
            if (is_pbch && !do_push) begin
                overflow_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= fifo_word_t'{data: llr_i.data, last: llr_i.last};
        end
    end

    // zero head when empty
    always_comb begin
        head_o = '0;
        if (!empty) begin
            head_o.data = mem_q[rd_ptr_q].data;
            head_o.kind = LLR_PBCH;
            head_o.last = mem_q[rd_ptr_q].last;
        end
    end

    assign status_o.overflow = overflow_q;
    assign status_o.level    = count_q;

endmodule

/* source/receiver_top.sv */
module receiver_top (
    input  logic                       clk_i,
    input  logic                       reset_ni,
    input  rx_pkg::iq_sample_t         sample_i,
    input  logic                       sample_valid_i,
    input  rx_pkg::cfo_inc_t           cfo_inc_i,
    input  logic                       cfo_valid_i,
    input  rx_pkg::cell_id_t           cell_id_i,
    input  logic                       n_id_2_valid_i,
    input  logic                       n_id_valid_i,
    input  logic                       ibar_valid_i,
    input  rx_pkg::llr_beat_t          llr_i,
    input  logic                       llr_valid_i,
    input  logic                       req_i,
    input  reg_pkg::bus_req_t          bus_req_i,
    output logic                       ack_o,
    output logic [reg_pkg::REG_DW-1:0] rdata_o,
    output rx_pkg::phase_t             phase_o
);
    import rx_pkg::*;
    import reg_pkg::*;

    cfo_mode_e    cfo_mode;
    cfo_inc_t     cfo_acc;
    iq_sample_t   last_sample;
    cell_id_t     cell_id;
    llr_beat_t    pbch_head;
    pbch_status_t pbch_status;
    logic         pbch_pop;
    logic         pbch_clear;

    cfo_phase_acc cfo_phase_acc_i (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_valid_i (sample_valid_i),
        .cfo_inc_i      (cfo_inc_i),
        .cfo_valid_i    (cfo_valid_i),
        .cfo_mode_i     (cfo_mode),
        .cfo_acc_o      (cfo_acc),
        .phase_o        (phase_o)
    );

    cell_status cell_status_i (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .cell_id_i      (cell_id_i),
        .n_id_2_valid_i (n_id_2_valid_i),
        .n_id_valid_i   (n_id_valid_i),
        .ibar_valid_i   (ibar_valid_i),
        .last_sample_o  (last_sample),
        .cell_id_o      (cell_id)
    );

    // only pbch beats reach the host
    pbch_llr_fifo pbch_llr_fifo_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .llr_i       (llr_i),
        .llr_valid_i (llr_valid_i),
        .pop_i       (pbch_pop),
        .clear_i     (pbch_clear),
        .head_o      (pbch_head),
        .status_o    (pbch_status)
    );

    reg_bus_slave reg_bus_slave_i (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .req_i         (req_i),
        .bus_req_i     (bus_req_i),
        .cfo_acc_i     (cfo_acc),
        .last_sample_i (last_sample),
        .cell_id_i     (cell_id),
        .pbch_head_i   (pbch_head),
        .pbch_status_i (pbch_status),
        .ack_o         (ack_o),
        .rdata_o       (rdata_o),
        .cfo_mode_o    (cfo_mode),
        .pbch_pop_o    (pbch_pop),
        .pbch_clear_o  (pbch_clear)
    );

endmodule

/* source/reg_bus_slave.sv */
module reg_bus_slave (
    input  logic                          clk_i,
    input  logic                          reset_ni,
    input  logic                          req_i,
    input  reg_pkg::bus_req_t             bus_req_i,
    input  rx_pkg::cfo_inc_t              cfo_acc_i,
    input  rx_pkg::iq_sample_t            last_sample_i,
    input  rx_pkg::cell_id_t              cell_id_i,
    input  rx_pkg::llr_beat_t             pbch_head_i,
    input  reg_pkg::pbch_status_t         pbch_status_i,
    output logic                          ack_o,
    output logic [reg_pkg::REG_DW-1:0]    rdata_o,
    output rx_pkg::cfo_mode_e             cfo_mode_o,
    output logic                          pbch_pop_o,
    output logic                          pbch_clear_o
);
    import rx_pkg::*;
    import reg_pkg::*;

    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_ACK,
        BUS_WAIT_LOW
    } bus_state_e;

    bus_state_e        state_q;
    logic              ack_q;
    logic [REG_DW-1:0] rdata_q;
    logic [REG_DW-1:0] rdata_mux;
    cfo_mode_e         cfo_mode_q;
    logic              pop_q;
    logic              clear_q;

    // ----------------------------------------------------------------------
    // read mux
    // ----------------------------------------------------------------------
    always_comb begin
        rdata_mux = '0;
        case (bus_req_i.addr)
            REG_CELL_ID:   rdata_mux = REG_DW'(cell_id_i);
            REG_RX_SAMPLE: rdata_mux = REG_DW'(last_sample_i);
            REG_CFO_INC:   rdata_mux = REG_DW'(cfo_acc_i);
            REG_CFO_MODE:  rdata_mux = REG_DW'(cfo_mode_q);
            REG_PBCH_LEVEL: begin
                rdata_mux[PBCH_LEVEL_W-1:0] = pbch_status_i.level;
                rdata_mux[PBCH_OVF_BIT]     = pbch_status_i.overflow;
            end
            REG_PBCH_DATA: begin
                rdata_mux[LLR_DW-1:0]   = pbch_head_i.data;
                rdata_mux[PBCH_LAST_BIT] = pbch_head_i.last;
            end
            default: rdata_mux = '0;
        endcase
    end

    // ----------------------------------------------------------------------
    // four-phase handshake
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q    <= BUS_IDLE;
            ack_q      <= 1'b0;
            cfo_mode_q <= CFO_TRACK;
            pop_q      <= 1'b0;
            clear_q    <= 1'b0;
        end else begin
            pop_q   <= 1'b0;
            clear_q <= 1'b0;
            // ack lags the state by one edge on both sides
            ack_q   <= (state_q != BUS_IDLE);
            case (state_q)
                BUS_IDLE: begin
                    if (req_i) begin
                        state_q <= BUS_ACK;
                        if (bus_req_i.write) begin
                            if (bus_req_i.addr == REG_CFO_MODE) begin
                                cfo_mode_q <= cfo_mode_e'(bus_req_i.wdata[0]);
                            end
                            if (bus_req_i.addr == REG_PBCH_LEVEL) begin
                                clear_q <= 1'b1;
                            end
                        end else if (bus_req_i.addr == REG_PBCH_DATA &&
                                     pbch_status_i.level != '0) begin
                            pop_q <= 1'b1;
                        end
                    end
                end
                BUS_ACK: state_q <= BUS_WAIT_LOW;
                BUS_WAIT_LOW: begin
                    if (!req_i) begin
                        state_q <= BUS_IDLE;
                    end
                end
                default: state_q <= BUS_IDLE;
            endcase
        end
    end

    // read data captured with the head before the pop lands
    always_ff @(posedge clk_i) begin
        if (state_q == BUS_IDLE && req_i) begin
            rdata_q <= bus_req_i.write ? '0 : rdata_mux;
        end
    end

    assign ack_o        = ack_q;
    assign rdata_o      = rdata_q;
    assign cfo_mode_o   = cfo_mode_q;
    assign pbch_pop_o   = pop_q;
    assign pbch_clear_o = clear_q;

endmodule

/* source/reg_pkg.sv */
package reg_pkg;

    localparam int REG_AW = 4;
    localparam int REG_DW = 32;

    // word addresses
    typedef enum logic [REG_AW-1:0] {
        REG_CELL_ID    = 4'd0,
        REG_RX_SAMPLE  = 4'd1,
        REG_CFO_INC    = 4'd2,
        REG_CFO_MODE   = 4'd3,
        REG_PBCH_LEVEL = 4'd4,
        REG_PBCH_DATA  = 4'd5
    } reg_addr_e;

    typedef struct packed {
        logic              write;
        reg_addr_e         addr;
        logic [REG_DW-1:0] wdata;
    } bus_req_t;

    // pbch fifo register fields
    localparam int PBCH_LEVEL_W  = 5;
    localparam int PBCH_OVF_BIT  = 31;
    localparam int PBCH_LAST_BIT = 8;

    typedef struct packed {
        logic                    overflow;
        logic [PBCH_LEVEL_W-1:0] level;
    } pbch_status_t;

endpackage

/* source/rx_pkg.sv */
package rx_pkg;

    // baseband samples
    localparam int SAMPLE_DW = 16;

    typedef struct packed {
        logic [SAMPLE_DW-1:0] im;
        logic [SAMPLE_DW-1:0] re;
    } iq_sample_t;

    // rotator phase and cfo increment
    localparam int DDS_PHASE_DW = 20;

    typedef logic [DDS_PHASE_DW-1:0] phase_t;
    typedef logic signed [DDS_PHASE_DW-1:0] cfo_inc_t;

    typedef enum logic {
        CFO_TRACK  = 1'b0,
        CFO_MANUAL = 1'b1
    } cfo_mode_e;

    // cell identity
    localparam int N_ID_MAX = 1007;

    typedef struct packed {
        logic [$clog2(N_ID_MAX)-1:0] n_id;
        logic [1:0]                  n_id_2;
        logic [2:0]                  ibar_ssb;
    } cell_id_t;

    // demapper output
    localparam int LLR_DW = 8;

    typedef enum logic [1:0] {
        LLR_NONE  = 2'd0,
        LLR_PBCH  = 2'd1,
        LLR_DMRS  = 2'd2,
        LLR_OTHER = 2'd3
    } llr_kind_e;

    typedef struct packed {
        logic [LLR_DW-1:0] data;
        llr_kind_e         kind;
        logic              last;
    } llr_beat_t;

    localparam int PBCH_FIFO_DEPTH = 16;
    localparam int PBCH_PTR_W = $clog2(PBCH_FIFO_DEPTH);

endpackage
